// ==== design/mem_map_pkg.sv ====
// Physical memory map, device codes, host-interface address and command codes, access sizes
package mem_map_pkg;

    // Datapath widths
    localparam int WORD_W = 32;
    localparam int LINE_W = 128;

    // Device nibble, address bits 31 to 28
    //   0x0, 0x8  DRAM
    //   0x4       VirtIO-style window, sub-device in bits 27 to 24
    //   0x5       PLIC
    //   0x6       CLINT
    localparam logic [3:0] DEV_DRAM_LO = 4'h0;
    localparam logic [3:0] DEV_DRAM_HI = 4'h8;
    localparam logic [3:0] DEV_VIRTIO  = 4'h4;
    localparam logic [3:0] DEV_PLIC    = 4'h5;
    localparam logic [3:0] DEV_CLINT   = 4'h6;

    // Sub-devices inside the VirtIO window
    localparam logic [3:0] VIRT_CONSOLE = 4'd0;
    localparam logic [3:0] VIRT_FB      = 4'd5;

    // Host interface word, sits on top of the console registers
    // and takes priority over them
    localparam logic [WORD_W-1:0] TOHOST_ADDR = 32'h4000_0000;

    // Command codes, upper halfword of the host-interface word
    localparam logic [15:0] CMD_PRINT_CHAR = 16'h0101;
    localparam logic [15:0] CMD_POWER_OFF  = 16'h0102;

    // DRAM port sees 27 offset bits only
    localparam logic [WORD_W-1:0] DRAM_OFFSET_MASK = 32'h07ff_ffff;

    // Load and store sizes, funct3 encoding
    localparam logic [2:0] FUNCT3_LB  = 3'd0;
    localparam logic [2:0] FUNCT3_LH  = 3'd1;
    localparam logic [2:0] FUNCT3_LW  = 3'd2;
    localparam logic [2:0] FUNCT3_LBU = 3'd4;
    localparam logic [2:0] FUNCT3_LHU = 3'd5;
    localparam logic [2:0] FUNCT3_SW  = 3'd2;

endpackage

// ==== design/bus_pkg.sv ====
// Request, device strobe and read-return selection structs of the interconnect
package bus_pkg;

    import mem_map_pkg::*;

    // CPU data request, one cycle level
    typedef struct packed {
        logic [WORD_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
        // funct3 of the load or store
        logic [2:0]        ctrl;
        logic              we;
        logic              re;
    } mem_req_t;

    // Write and read strobes towards the devices
    typedef struct packed {
        logic cons_we;
        logic fb_we;
        logic plic_we;
        logic plic_re;
        logic clint_we;
    } dev_strobe_t;

    // What the return path needs to know about the last access
    typedef struct packed {
        // Device nibble and VirtIO sub-device
        logic [3:0] dev;
        logic [3:0] virt;
        // Byte position inside the 128-bit line
        logic [3:0] byte_off;
        logic [2:0] ctrl;
    } ret_sel_t;

endpackage

// ==== design/request_decoder.sv ====
// Address decoder steering data requests and instruction fetches to DRAM and devices
`timescale 1ns/1ps

module request_decoder (
    input  bus_pkg::mem_req_t               data_req,
    input  logic [mem_map_pkg::WORD_W-1:0]  insn_addr,
    input  logic                            dram_busy,
    output logic                            dram_rd_en,
    output logic                            dram_wr_en,
    output logic [mem_map_pkg::WORD_W-1:0]  dram_addr,
    output logic [mem_map_pkg::WORD_W-1:0]  dram_wdata,
    output logic [2:0]                      dram_ctrl,
    output bus_pkg::dev_strobe_t            dev_strobe,
    output logic                            tohost_we,
    output bus_pkg::ret_sel_t               sel,
    output logic                            sel_load
);
    import mem_map_pkg::*;

    logic [3:0]        dev;
    logic [3:0]        virt;
    logic              data_access;
    logic              is_tohost;
    logic              dram_hit;
    logic              in_virtio;
    logic [WORD_W-1:0] req_addr;

    // Device fields of the data address
    assign dev  = data_req.addr[31:28];
    assign virt = data_req.addr[27:24];

    assign data_access = data_req.re | data_req.we;
    assign is_tohost   = (data_req.addr == TOHOST_ADDR);
    assign dram_hit    = (dev == DEV_DRAM_LO) || (dev == DEV_DRAM_HI);
    assign in_virtio   = (dev == DEV_VIRTIO) && !is_tohost;

    // Fetch owns the DRAM port only when no data access is pending
    assign req_addr   = data_access ? data_req.addr : insn_addr;
    assign dram_addr  = req_addr & DRAM_OFFSET_MASK;
    assign dram_ctrl  = data_access ? data_req.ctrl : FUNCT3_LW;
    assign dram_wdata = data_req.wdata;

    // Busy holds off the DRAM port, nothing else
    assign dram_rd_en = !dram_busy && (!data_access || (data_req.re && dram_hit));
    assign dram_wr_en = !dram_busy && data_req.we && dram_hit;

    // Device strobes
    assign dev_strobe.cons_we  = data_req.we && in_virtio && (virt == VIRT_CONSOLE);
    assign dev_strobe.fb_we    = data_req.we && in_virtio && (virt == VIRT_FB);
    assign dev_strobe.plic_we  = data_req.we && (dev == DEV_PLIC);
    assign dev_strobe.plic_re  = data_req.re && (dev == DEV_PLIC);
    assign dev_strobe.clint_we = data_req.we && (dev == DEV_CLINT);

    assign tohost_we = data_req.we && is_tohost;

    // Selection of the access now on the bus, for the return path
    assign sel.dev      = req_addr[31:28];
    assign sel.virt     = req_addr[27:24];
    assign sel.byte_off = req_addr[3:0];
    assign sel.ctrl     = dram_ctrl;

    // Any DRAM transfer, or a device read which never waits for busy
    assign sel_load = dram_rd_en || dram_wr_en || (data_req.re && !dram_hit);

endmodule

// ==== design/tohost_unit.sv ====
// Host-interface command register with character output strobe and power-off finish flag
`timescale 1ns/1ps

module tohost_unit (
    input  logic                            CLK,
    input  logic                            rst,
    input  logic                            tohost_we,
    input  logic [mem_map_pkg::WORD_W-1:0]  wdata,
    output logic                            uart_we,
    output logic [7:0]                      uart_data,
    output logic                            finish
);
    import mem_map_pkg::*;

    logic [WORD_W-1:0] cmd_q;
    logic              is_print;
    logic              is_power_off;

    // Command code in the upper halfword
    assign is_print     = (cmd_q[31:16] == CMD_PRINT_CHAR);
    assign is_power_off = (cmd_q[31:16] == CMD_POWER_OFF);

    // New write wins, a printed character clears the word
    always_ff @(posedge CLK) begin
        if (rst) begin
            cmd_q <= '0;
        end else if (tohost_we) begin
            cmd_q <= wdata;
        end else if (is_print) begin
            cmd_q <= '0;
        end
    end

    // One cycle strobe, one cycle after the command is held
    always_ff @(posedge CLK) begin
        if (rst) begin
            uart_we <= 1'b0;
        end else begin
            uart_we <= is_print;
        end
    end

    always_ff @(posedge CLK) begin
        if (is_print) begin
            uart_data <= cmd_q[7:0];
        end
    end

    // Sticky until reset
    always_ff @(posedge CLK) begin
        if (rst) begin
            finish <= 1'b0;
        end else if (is_power_off) begin
            finish <= 1'b1;
        end
    end

endmodule

// ==== design/read_return.sv ====
// Read return path: registered access selection, DRAM load alignment and device read mux
`timescale 1ns/1ps

module read_return (
    input  logic                            CLK,
    input  logic                            rst,
    input  logic                            sel_load,
    input  bus_pkg::ret_sel_t               sel,
    input  logic [mem_map_pkg::LINE_W-1:0]  dram_rdata,
    input  logic [mem_map_pkg::WORD_W-1:0]  clint_rdata,
    input  logic [mem_map_pkg::WORD_W-1:0]  plic_rdata,
    input  logic [mem_map_pkg::WORD_W-1:0]  cons_rdata,
    input  logic [mem_map_pkg::WORD_W-1:0]  fb_rdata,
    output logic [mem_map_pkg::WORD_W-1:0]  data_rdata,
    output logic                            is_dram_data
);
    import mem_map_pkg::*;
    import bus_pkg::*;

    ret_sel_t          sel_q;
    logic [LINE_W-1:0] line_shift;
    logic [WORD_W-1:0] raw_word;
    logic [WORD_W-1:0] dram_word;
    logic [WORD_W-1:0] dev_word;

    // Selection of the last access, DRAM after reset
    always_ff @(posedge CLK) begin
        if (rst) begin
            sel_q     <= '0;
            sel_q.dev <= DEV_DRAM_LO;
        end else if (sel_load) begin
            sel_q <= sel;
        end
    end

    // Byte offset to bit shift
    assign line_shift = dram_rdata >> {sel_q.byte_off, 3'b000};
    assign raw_word   = line_shift[WORD_W-1:0];

    always_comb begin
        case (sel_q.ctrl)
            FUNCT3_LB:  dram_word = {{24{raw_word[7]}}, raw_word[7:0]};
            FUNCT3_LH:  dram_word = {{16{raw_word[15]}}, raw_word[15:0]};
            FUNCT3_LBU: dram_word = {24'h0, raw_word[7:0]};
            FUNCT3_LHU: dram_word = {16'h0, raw_word[15:0]};
            default:    dram_word = raw_word;
        endcase
    end

    // Anything not mapped to a device is served by DRAM
    always_comb begin
        is_dram_data = 1'b0;
        case (sel_q.dev)
            DEV_CLINT: dev_word = clint_rdata;
            DEV_PLIC:  dev_word = plic_rdata;
            DEV_VIRTIO: begin
                case (sel_q.virt)
                    VIRT_CONSOLE: dev_word = cons_rdata;
                    VIRT_FB:      dev_word = fb_rdata;
                    default:      dev_word = '0;
                endcase
            end
            default: begin
                dev_word     = '0;
                is_dram_data = 1'b1;
            end
        endcase
    end

    assign data_rdata = is_dram_data ? dram_word : dev_word;

endmodule

// ==== design/mem_interconnect.sv ====
// Top level of the physical memory interconnect: decoder, host interface and read return
`timescale 1ns/1ps

module mem_interconnect (
    input  logic                            CLK,
    input  logic                            rst,
    input  bus_pkg::mem_req_t               data_req,
    input  logic [mem_map_pkg::WORD_W-1:0]  insn_addr,
    input  logic                            dram_busy,
    input  logic [mem_map_pkg::LINE_W-1:0]  dram_rdata,
    input  logic [mem_map_pkg::WORD_W-1:0]  clint_rdata,
    input  logic [mem_map_pkg::WORD_W-1:0]  plic_rdata,
    input  logic [mem_map_pkg::WORD_W-1:0]  cons_rdata,
    input  logic [mem_map_pkg::WORD_W-1:0]  fb_rdata,
    output logic                            dram_rd_en,
    output logic                            dram_wr_en,
    output logic [mem_map_pkg::WORD_W-1:0]  dram_addr,
    output logic [mem_map_pkg::WORD_W-1:0]  dram_wdata,
    output logic [2:0]                      dram_ctrl,
    output bus_pkg::dev_strobe_t            dev_strobe,
    output logic [mem_map_pkg::WORD_W-1:0]  dev_wdata,
    output logic [mem_map_pkg::WORD_W-1:0]  data_rdata,
    output logic [mem_map_pkg::LINE_W-1:0]  insn_rdata,
    output logic                            is_dram_data,
    output logic                            uart_we,
    output logic [7:0]                      uart_data,
    output logic                            finish
);
    import bus_pkg::*;

    ret_sel_t sel;
    logic     sel_load;
    logic     tohost_we;

    request_decoder i_request_decoder (
        .data_req   (data_req),
        .insn_addr  (insn_addr),
        .dram_busy  (dram_busy),
        .dram_rd_en (dram_rd_en),
        .dram_wr_en (dram_wr_en),
        .dram_addr  (dram_addr),
        .dram_wdata (dram_wdata),
        .dram_ctrl  (dram_ctrl),
        .dev_strobe (dev_strobe),
        .tohost_we  (tohost_we),
        .sel        (sel),
        .sel_load   (sel_load)
    );

    tohost_unit i_tohost_unit (
        .CLK       (CLK),
        .rst       (rst),
        .tohost_we (tohost_we),
        .wdata     (data_req.wdata),
        .uart_we   (uart_we),
        .uart_data (uart_data),
        .finish    (finish)
    );

    read_return i_read_return (
        .CLK          (CLK),
        .rst          (rst),
        .sel_load     (sel_load),
        .sel          (sel),
        .dram_rdata   (dram_rdata),
        .clint_rdata  (clint_rdata),
        .plic_rdata   (plic_rdata),
        .cons_rdata   (cons_rdata),
        .fb_rdata     (fb_rdata),
        .data_rdata   (data_rdata),
        .is_dram_data (is_dram_data)
    );

    // Fetch takes the whole line, devices share the store data
    assign insn_rdata = dram_rdata;
    assign dev_wdata  = data_req.wdata;

endmodule

// ==== testbench/tb_mem_interconnect.sv ====
// Testbench for the memory interconnect with file-driven accesses, a DRAM line model and checks
`timescale 1ns/1ps

module tb_mem_interconnect;
    import mem_map_pkg::*;
    import bus_pkg::*;

    logic                CLK = 1'b0;
    logic                rst;
    mem_req_t            data_req;
    logic [WORD_W-1:0]   insn_addr;
    logic                dram_busy;
    logic [LINE_W-1:0]   dram_rdata = '0;
    logic [WORD_W-1:0]   clint_rdata;
    logic [WORD_W-1:0]   plic_rdata;
    logic [WORD_W-1:0]   cons_rdata;
    logic [WORD_W-1:0]   fb_rdata;
    logic                dram_rd_en;
    logic                dram_wr_en;
    logic [WORD_W-1:0]   dram_addr;
    logic [WORD_W-1:0]   dram_wdata;
    logic [2:0]          dram_ctrl;
    dev_strobe_t         dev_strobe;
    logic [WORD_W-1:0]   dev_wdata;
    logic [WORD_W-1:0]   data_rdata;
    logic [LINE_W-1:0]   insn_rdata;
    logic                is_dram_data;
    logic                uart_we;
    logic [7:0]          uart_data;
    logic                finish;

    int                  errors;
    int                  checks;
    int                  vectors;
    int                  fd;
    int                  fields_read;
    string               text;
    logic [31:0]         col [9];

    mem_interconnect i_mem_interconnect (
        .CLK          (CLK),
        .rst          (rst),
        .data_req     (data_req),
        .insn_addr    (insn_addr),
        .dram_busy    (dram_busy),
        .dram_rdata   (dram_rdata),
        .clint_rdata  (clint_rdata),
        .plic_rdata   (plic_rdata),
        .cons_rdata   (cons_rdata),
        .fb_rdata     (fb_rdata),
        .dram_rd_en   (dram_rd_en),
        .dram_wr_en   (dram_wr_en),
        .dram_addr    (dram_addr),
        .dram_wdata   (dram_wdata),
        .dram_ctrl    (dram_ctrl),
        .dev_strobe   (dev_strobe),
        .dev_wdata    (dev_wdata),
        .data_rdata   (data_rdata),
        .insn_rdata   (insn_rdata),
        .is_dram_data (is_dram_data),
        .uart_we      (uart_we),
        .uart_data    (uart_data),
        .finish       (finish)
    );

    always #4 CLK = ~CLK;

    // Byte at address A holds A[7:0], so a line is its base byte counting up
    function automatic logic [LINE_W-1:0] model_line(input logic [WORD_W-1:0] addr);
        logic [LINE_W-1:0] line;
        logic [7:0]        base;
        base = {addr[7:4], 4'h0};
        for (int k = 0; k < 16; k++) begin
            line[8*k +: 8] = base + 8'(k);
        end
        return line;
    endfunction

    // DRAM answers one cycle after the read enable
    always @(posedge CLK) begin
        if (dram_rd_en) begin
            dram_rdata <= model_line(dram_addr);
        end
    end

    task automatic check_val(input string what, input logic [127:0] got,
                             input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] time %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic drive_idle;
        data_req  <= '0;
        insn_addr <= 32'h0000_0100;
    endtask

    task automatic run_vector(input logic [31:0] kind, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [31:0] ctrl,
                              input logic [31:0] we, input logic [31:0] re,
                              input logic [31:0] busy, input logic [31:0] strobe,
                              input logic [31:0] expected);
        mem_req_t req;
        int       i;
        int       waited;
        logic     flag;
        req.addr  = addr;
        req.wdata = wdata;
        req.ctrl  = ctrl[2:0];
        req.we    = we[0];
        req.re    = re[0];
        @(posedge CLK);
        if (kind == 3) begin
            data_req  <= '0;
            insn_addr <= addr;
        end else begin
            data_req <= req;
        end
        dram_busy <= (busy != 0);
        // Request is held while DRAM is busy
        for (i = 0; i < int'(busy); i++) begin
            @(negedge CLK);
            check_val("dram_rd_en while busy", 128'(dram_rd_en), 128'(0));
            check_val("dram_wr_en while busy", 128'(dram_wr_en), 128'(0));
            @(posedge CLK);
        end
        dram_busy <= 1'b0;

        @(negedge CLK);
        check_val("dev_strobe", 128'(dev_strobe), 128'(strobe[4:0]));
        case (kind)
            0, 3:    check_val("dram_rd_en", 128'(dram_rd_en), 128'(1));
            1:       check_val("dram_wr_en", 128'(dram_wr_en), 128'(expected[0]));
            default: check_val("dram_wr_en", 128'(dram_wr_en), 128'(0));
        endcase
        // DRAM port keeps the low 27 address bits
        if (kind == 0 || kind == 3 || (kind == 1 && expected[0])) begin
            check_val("dram_addr", 128'(dram_addr), 128'({5'b0, addr[26:0]}));
        end
        if (kind == 0) begin
            check_val("load dram_ctrl", 128'(dram_ctrl), 128'(ctrl[2:0]));
        end
        if (kind == 1) begin
            check_val("dram_wdata", 128'(dram_wdata), 128'(wdata));
            check_val("dev_wdata", 128'(dev_wdata), 128'(wdata));
        end
        if (kind == 3) begin
            check_val("fetch dram_ctrl", 128'(dram_ctrl), 128'(FUNCT3_LW));
        end

        // Return cycle
        @(posedge CLK);
        drive_idle();
        @(negedge CLK);
        if (kind == 0 || kind == 2 || kind == 3) begin
            check_val("data_rdata", 128'(data_rdata), 128'(expected));
            check_val("is_dram_data", 128'(is_dram_data), 128'(kind != 2));
        end
        if (kind == 3) begin
            check_val("insn_rdata", insn_rdata, model_line(addr));
        end
        if (kind == 4 || kind == 5) begin
            waited = 1;
            flag   = (kind == 4) ? uart_we : finish;
            while (!flag && waited < 20) begin
                @(negedge CLK);
                waited++;
                flag = (kind == 4) ? uart_we : finish;
            end
            if (!flag) begin
                errors++;
                $display("Timed out after %0d cycles waiting for the host-interface output",
                         waited);
            end else begin
                check_val("host output cycle", 128'(waited), 128'(2));
                if (kind == 4) begin
                    check_val("uart_data", 128'(uart_data), 128'(expected[7:0]));
                    @(negedge CLK);
                    check_val("uart_we after strobe", 128'(uart_we), 128'(0));
                end else begin
                    repeat (3) begin
                        @(negedge CLK);
                        check_val("finish held", 128'(finish), 128'(1));
                    end
                end
            end
        end
    endtask

    initial begin
        rst         = 1'b1;
        data_req    = '0;
        insn_addr   = 32'h0000_0100;
        dram_busy   = 1'b0;
        cons_rdata  = 32'h4c4c_0000;
        fb_rdata    = 32'h4f4f_0005;
        plic_rdata  = 32'h5e5e_0005;
        clint_rdata = 32'h6c6c_0006;
        errors      = 0;
        checks      = 0;
        vectors     = 0;
        repeat (4) @(posedge CLK);
        rst <= 1'b0;
        @(negedge CLK);
        check_val("uart_we after reset", 128'(uart_we), 128'(0));
        check_val("finish after reset", 128'(finish), 128'(0));
        check_val("is_dram_data after reset", 128'(is_dram_data), 128'(1));

        fd = $fopen("testbench/interconnect_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open testbench/interconnect_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                text = "";
                void'($fgets(text, fd));
                if (text.len() > 0 && text.getc(0) != "#") begin
                    fields_read = $sscanf(text, "%h %h %h %h %h %h %h %h %h", col[0], col[1],
                                          col[2], col[3], col[4], col[5], col[6], col[7],
                                          col[8]);
                    if (fields_read == 9) begin
                        vectors++;
                        run_vector(col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                                   col[7], col[8]);
                    end
                end
            end
            $fclose(fd);
        end
        if (vectors == 0) begin
            errors++;
            $display("No test vectors were read from the stimulus file");
        end

        $display("Vectors: %0d, checks: %0d, errors: %0d", vectors, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/interconnect_tests.txt ====
# Columns in hex: kind addr wdata ctrl we re busy_cycles strobe expected
# Kinds 0 load, 1 write, 2 device read, 3 fetch, 4 print char, 5 power off
0 80000085 00000000 0 0 1 0 00 ffffff85
0 80000085 00000000 4 0 1 0 00 00000085
0 00002013 00000000 0 0 1 0 00 00000013
0 00002032 00000000 1 0 1 0 00 00003332
0 000010f6 00000000 1 0 1 0 00 fffff7f6
0 000010f6 00000000 5 0 1 0 00 0000f7f6
0 8000004c 00000000 2 0 1 0 00 4f4e4d4c
0 000000a8 00000000 2 0 1 3 00 abaaa9a8
1 40000010 12345678 2 1 0 0 10 00000000
1 45000000 00ff00ff 2 1 0 0 08 00000000
1 50000004 00000007 2 1 0 0 04 00000000
1 60000008 0000beef 2 1 0 0 01 00000000
1 80000040 cafef00d 2 1 0 0 00 00000001
2 40000004 00000000 2 0 1 0 00 4c4c0000
2 45000000 00000000 2 0 1 0 00 4f4f0005
2 50000000 00000000 2 0 1 0 02 5e5e0005
2 60000000 00000000 2 0 1 0 00 6c6c0006
2 43000000 00000000 2 0 1 0 00 00000000
3 000002c4 00000000 2 0 0 0 00 c7c6c5c4
4 40000000 01010041 2 1 0 0 00 00000041
5 40000000 01020000 2 1 0 0 00 00000001

// ==== vlog.f ====
design/mem_map_pkg.sv
design/bus_pkg.sv
design/request_decoder.sv
design/tohost_unit.sv
design/read_return.sv
design/mem_interconnect.sv
testbench/tb_mem_interconnect.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_mem_interconnect \
    -Mdir obj_dir -o sim_tb \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/sim_tb | tee /dev/stderr | grep -q "^STATUS: PASS$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
